// ==== src/stu_pkg.sv ====
/*
 * Shared definitions of the store path
 * Data and address word type, store width encoding and store packet
 * Memory map boundaries and store buffer sizing
 */

package stu_pkg;

    // ==========================================================
    // Basic types
    // ==========================================================

    // Data and address words share the same width
    typedef logic [31:0] data_word_t;

    // Width of a store operation as issued by the execution stage
    typedef enum logic [1:0] {
        STORE_BYTE,
        STORE_HALF,
        STORE_WORD
    } store_width_t;

    // A complete store as it moves through unit, buffer and controller
    typedef struct packed {
        data_word_t   data;
        data_word_t   address;
        store_width_t width;
    } store_packet_t;

    // ==========================================================
    // Memory map
    // ==========================================================

    // Every region is half open, the start is inside and the end is outside
    // Boot region spans [0, BOOT_END) and cannot be written
    localparam data_word_t BOOT_END    = 32'h0000_1000;

    // Memory mapped timer, written through a dedicated strobe
    localparam data_word_t TIMER_START = 32'h0000_1000;
    localparam data_word_t TIMER_END   = 32'h0000_1010;

    // IO spans [TIMER_END, IO_END), main memory starts at IO_END
    localparam data_word_t IO_END      = 32'h0000_2000;

    // ==========================================================
    // Store buffer sizing
    // ==========================================================

    // The depth is a power of two so the pointers wrap on their own
    localparam int STORE_BUFFER_DEPTH = 4;
    localparam int STORE_BUFFER_PTR_W = 2;

endpackage : stu_pkg

// ==== src/store_unit.sv ====
/*
 * Store unit
 * Decodes the store address against the memory map and steers each
 * store to the timer strobe, the store buffer, the direct memory
 * channel or the illegal access flag, then holds the result until taken
 */

`timescale 1ns/1ps

module store_unit (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  prv_level_i,
    input  logic                  valid_operation_i,
    input  stu_pkg::store_packet_t store_packet_i,
    input  logic                  data_accepted_i,

    // Store buffer push side
    input  logic                  buf_full_i,
    output logic                  push_o,
    output stu_pkg::store_packet_t push_packet_o,

    // Direct channel towards the store controller
    input  logic                  ctrl_idle_i,
    input  logic                  direct_done_i,
    output logic                  direct_req_o,
    output stu_pkg::store_packet_t direct_packet_o,

    // Memory mapped timer
    output logic                  timer_write_o,
    output stu_pkg::store_packet_t timer_packet_o,

    // Status towards the issue stage
    output logic                  idle_o,
    output logic                  data_valid_o,
    output logic                  illegal_access_o
);

    // ==========================================================
    // Address decode
    // ==========================================================

    logic timer_access;
    logic boot_access;
    logic io_access;
    logic bufferable;
    logic legal;

    // Ranges are half open, matching the package map
    assign boot_access  = store_packet_i.address < stu_pkg::BOOT_END;
    assign timer_access = (store_packet_i.address >= stu_pkg::TIMER_START) &&
                          (store_packet_i.address < stu_pkg::TIMER_END);
    assign io_access    = (store_packet_i.address >= stu_pkg::TIMER_END) &&
                          (store_packet_i.address < stu_pkg::IO_END);
    assign bufferable   = store_packet_i.address >= stu_pkg::IO_END;

    // IO needs machine mode, boot is never writable
    assign legal = !boot_access && (timer_access || bufferable || (io_access && prv_level_i));

    // ==========================================================
    // FSM
    // ==========================================================

    typedef enum logic [1:0] {IDLE, WAIT_MEMORY, WAIT_BUFFER, WAIT_ACCEPT} unit_state_t;

    unit_state_t           state_q;
    unit_state_t           state_d;
    stu_pkg::store_packet_t packet_q;
    stu_pkg::store_packet_t out_packet;
    logic                  legal_q;
    logic                  issue;

    // A store is taken only while the unit sits in IDLE
    assign idle_o = (state_q == IDLE);
    assign issue  = valid_operation_i && idle_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            legal_q <= 1'b1;
        end else begin
            state_q <= state_d;
            if (issue) begin
                legal_q <= legal;
            end
        end
    end

    // Payload copy of the issued store, used after the IDLE cycle
    always_ff @(posedge clk_i) begin
        if (issue) begin
            packet_q <= store_packet_i;
        end
    end

    // In IDLE the incoming store is forwarded without waiting a cycle
    assign out_packet      = idle_o ? store_packet_i : packet_q;
    assign push_packet_o   = out_packet;
    assign direct_packet_o = out_packet;

    // The timer write completes in the issue cycle itself
    assign timer_write_o  = issue && timer_access;
    assign timer_packet_o = store_packet_i;

    always_comb begin
        state_d      = state_q;
        push_o       = 1'b0;
        direct_req_o = 1'b0;

        case (state_q)
            IDLE: begin
                if (issue && !timer_access) begin
                    if (!legal) begin
                        // Nothing to send, only report the exception
                        state_d = WAIT_ACCEPT;
                    end else if (bufferable) begin
                        push_o  = !buf_full_i;
                        state_d = buf_full_i ? WAIT_BUFFER : WAIT_ACCEPT;
                    end else begin
                        direct_req_o = ctrl_idle_i;
                        state_d      = WAIT_MEMORY;
                    end
                end
            end

            WAIT_MEMORY: begin
                // The controller leaves idle as soon as it latches the request
                direct_req_o = ctrl_idle_i;
                if (direct_done_i) begin
                    state_d = WAIT_ACCEPT;
                end
            end

            WAIT_BUFFER: begin
                // Retry the push until a slot frees up
                push_o = !buf_full_i;
                if (!buf_full_i) begin
                    state_d = WAIT_ACCEPT;
                end
            end

            WAIT_ACCEPT: begin
                if (data_accepted_i) begin
                    state_d = IDLE;
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // Result is held until the issue stage accepts it
    assign data_valid_o     = (state_q == WAIT_ACCEPT);
    assign illegal_access_o = data_valid_o && !legal_q;

endmodule : store_unit

// ==== src/store_buffer.sv ====
/*
 * Store buffer
 * Circular FIFO of store packets with full and empty flags
 */

`timescale 1ns/1ps

module store_buffer (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Push side, driven by the store unit
    input  logic                  push_i,
    input  stu_pkg::store_packet_t push_packet_i,

    // Pop side, driven by the store controller
    input  logic                  pop_i,
    output stu_pkg::store_packet_t head_packet_o,

    output logic                  full_o,
    output logic                  empty_o
);

    // ==========================================================
    // Storage and pointers
    // ==========================================================

    stu_pkg::store_packet_t entries_q [stu_pkg::STORE_BUFFER_DEPTH];

    logic [stu_pkg::STORE_BUFFER_PTR_W-1:0] wr_ptr_q;
    logic [stu_pkg::STORE_BUFFER_PTR_W-1:0] rd_ptr_q;
    logic [stu_pkg::STORE_BUFFER_PTR_W:0]   count_q;

    logic do_push;
    logic do_pop;

    assign full_o  = (count_q == (stu_pkg::STORE_BUFFER_PTR_W + 1)'(stu_pkg::STORE_BUFFER_DEPTH));
    assign empty_o = (count_q == '0);

    // Requests against a full or empty buffer are dropped here
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            entries_q[wr_ptr_q] <= push_packet_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end

            // Simultaneous push and pop leave the count unchanged
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Oldest entry is visible without a read latency
    assign head_packet_o = entries_q[rd_ptr_q];

endmodule : store_buffer

// ==== src/store_controller.sv ====
/*
 * Store controller
 * Picks direct requests over buffered stores and runs one write at a
 * time on the external memory port
 */

`timescale 1ns/1ps

module store_controller (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Direct channel from the store unit
    input  logic                  direct_req_i,
    input  stu_pkg::store_packet_t direct_packet_i,
    output logic                  direct_done_o,

    // Store buffer read side
    input  logic                  buf_empty_i,
    input  stu_pkg::store_packet_t head_packet_i,
    output logic                  pop_o,

    output logic                  idle_o,

    // External memory write port
    output logic                  mem_req_o,
    output stu_pkg::store_packet_t mem_packet_o,
    input  logic                  mem_done_i
);

    // ==========================================================
    // FSM
    // ==========================================================

    typedef enum logic {CTRL_IDLE, CTRL_BUSY} ctrl_state_t;

    ctrl_state_t           state_q;
    stu_pkg::store_packet_t packet_q;
    logic                  from_direct_q;
    logic                  start_direct;
    logic                  start_buffer;

    assign idle_o = (state_q == CTRL_IDLE);

    // Direct stores are not bufferable and win over queued entries
    assign start_direct = idle_o && direct_req_i;
    assign start_buffer = idle_o && !direct_req_i && !buf_empty_i;

    // The buffer entry leaves the queue as its write begins
    assign pop_o = start_buffer;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q       <= CTRL_IDLE;
            from_direct_q <= 1'b0;
        end else begin
            case (state_q)
                CTRL_IDLE: begin
                    if (start_direct || start_buffer) begin
                        state_q       <= CTRL_BUSY;
                        from_direct_q <= start_direct;
                    end
                end
                CTRL_BUSY: begin
                    if (mem_done_i) begin
                        state_q <= CTRL_IDLE;
                    end
                end
                default: state_q <= CTRL_IDLE;
            endcase
        end
    end

    // Packet stays stable for the whole memory transaction
    always_ff @(posedge clk_i) begin
        if (start_direct) begin
            packet_q <= direct_packet_i;
        end else if (start_buffer) begin
            packet_q <= head_packet_i;
        end
    end

    assign mem_req_o    = (state_q == CTRL_BUSY);
    assign mem_packet_o = packet_q;

    // Only the direct channel waits on completion
    assign direct_done_o = mem_req_o && mem_done_i && from_direct_q;

endmodule : store_controller

// ==== src/store_subsystem.sv ====
/*
 * Store subsystem top level
 * Connects store unit, store buffer and store controller
 */

`timescale 1ns/1ps

module store_subsystem (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Issue side
    input  logic                  valid_operation_i,
    input  stu_pkg::store_packet_t store_packet_i,
    input  logic                  prv_level_i,
    input  logic                  data_accepted_i,
    output logic                  idle_o,
    output logic                  data_valid_o,
    output logic                  illegal_access_o,
    output logic                  timer_write_o,
    output stu_pkg::store_packet_t timer_packet_o,

    // Memory side
    output logic                  mem_req_o,
    output stu_pkg::store_packet_t mem_packet_o,
    input  logic                  mem_done_i
);

    // Unit to buffer
    logic                  push;
    stu_pkg::store_packet_t push_packet;
    logic                  full;

    // Buffer to controller
    logic                  empty;
    logic                  pop;
    stu_pkg::store_packet_t head_packet;

    // Unit to controller
    logic                  direct_req;
    stu_pkg::store_packet_t direct_packet;
    logic                  direct_done;
    logic                  ctrl_idle;

    store_unit u_store_unit (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .prv_level_i       (prv_level_i),
        .valid_operation_i (valid_operation_i),
        .store_packet_i    (store_packet_i),
        .data_accepted_i   (data_accepted_i),
        .buf_full_i        (full),
        .push_o            (push),
        .push_packet_o     (push_packet),
        .ctrl_idle_i       (ctrl_idle),
        .direct_done_i     (direct_done),
        .direct_req_o      (direct_req),
        .direct_packet_o   (direct_packet),
        .timer_write_o     (timer_write_o),
        .timer_packet_o    (timer_packet_o),
        .idle_o            (idle_o),
        .data_valid_o      (data_valid_o),
        .illegal_access_o  (illegal_access_o)
    );

    store_buffer u_store_buffer (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .push_i        (push),
        .push_packet_i (push_packet),
        .pop_i         (pop),
        .head_packet_o (head_packet),
        .full_o        (full),
        .empty_o       (empty)
    );

    store_controller u_store_controller (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .direct_req_i    (direct_req),
        .direct_packet_i (direct_packet),
        .direct_done_o   (direct_done),
        .buf_empty_i     (empty),
        .head_packet_i   (head_packet),
        .pop_o           (pop),
        .idle_o          (ctrl_idle),
        .mem_req_o       (mem_req_o),
        .mem_packet_o    (mem_packet_o),
        .mem_done_i      (mem_done_i)
    );

endmodule : store_subsystem

// ==== test/store_subsystem_props.sv ====
/*
 * Concurrent assertions on the store subsystem handshakes
 */

`timescale 1ns/1ps

module store_subsystem_props (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic                   push_i,
    input logic                   full_i,
    input logic                   idle_i,
    input logic                   data_valid_i,
    input logic                   timer_write_i,
    input logic                   mem_req_i,
    input logic                   mem_done_i,
    input stu_pkg::store_packet_t mem_packet_i
);

    // The buffer only sees a push while it has a free slot
    push_not_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> !full_i)
        else $error("push raised while the store buffer is full");

    // Packet must not move under an open memory request
    mem_packet_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (mem_req_i && !mem_done_i) |=> $stable(mem_packet_i))
        else $error("mem_packet_o changed during a memory request");

    idle_excludes_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(idle_i && data_valid_i))
        else $error("idle_o and data_valid_o high together");

    // Timer strobe lasts one cycle
    timer_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        timer_write_i |=> !timer_write_i)
        else $error("timer_write_o held for more than one cycle");

endmodule : store_subsystem_props

bind store_subsystem store_subsystem_props props_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .push_i        (push),
    .full_i        (full),
    .idle_i        (idle_o),
    .data_valid_i  (data_valid_o),
    .timer_write_i (timer_write_o),
    .mem_req_i     (mem_req_o),
    .mem_done_i    (mem_done_i),
    .mem_packet_i  (mem_packet_o)
);

// ==== test/store_subsystem_tb.sv ====
/*
 * Testbench for the store subsystem
 * Reads stores from a stimulus file, plays the issue stage and the memory,
 * and checks timer strobes, memory writes and results against a scoreboard
 */

`timescale 1ns/1ps

module store_subsystem_tb;

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   valid_operation_i;
    stu_pkg::store_packet_t store_packet_i;
    logic                   prv_level_i;
    logic                   data_accepted_i = 1'b0;
    logic                   idle_o;
    logic                   data_valid_o;
    logic                   illegal_access_o;
    logic                   timer_write_o;
    stu_pkg::store_packet_t timer_packet_o;
    logic                   mem_req_o;
    stu_pkg::store_packet_t mem_packet_o;
    logic                   mem_done_i = 1'b0;

    // Stores read from the stimulus file, in issue order
    stu_pkg::store_packet_t stim_pkt[$];
    logic                   stim_prv[$];
    logic [7:0]             stim_cls[$];

    // ==========================================================
    // Scoreboard state
    // ==========================================================

    stu_pkg::store_packet_t buf_exp[$];
    logic [7:0]             res_exp[$];
    stu_pkg::store_packet_t direct_pkt;
    logic                   direct_pending = 1'b0;
    logic                   result_seen = 1'b0;
    int                     bypass_count = 0;
    int                     timer_count = 0;
    int                     exp_timer = 0;

    int seed = 32'h20d4_0347;
    int cycle_count = 0;
    int timeout_limit = 0;

    // Memory model countdown
    logic mem_armed = 1'b0;
    int   mem_wait = 0;

    store_subsystem dut_i (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .valid_operation_i (valid_operation_i),
        .store_packet_i    (store_packet_i),
        .prv_level_i       (prv_level_i),
        .data_accepted_i   (data_accepted_i),
        .idle_o            (idle_o),
        .data_valid_o      (data_valid_o),
        .illegal_access_o  (illegal_access_o),
        .timer_write_o     (timer_write_o),
        .timer_packet_o    (timer_packet_o),
        .mem_req_o         (mem_req_o),
        .mem_packet_o      (mem_packet_o),
        .mem_done_i        (mem_done_i)
    );

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic check_value(input string name, input logic [65:0] actual,
                               input logic [65:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_run(input string reason);
        $display("Error at %0t ns: %s", $time, reason);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    // Called at the edge where the DUT takes a store
    task automatic record_issue(input stu_pkg::store_packet_t pkt, input logic [7:0] cls);
        if (cls == "T") begin
            // Timer writes finish inside the issue cycle
            check_value("timer_write_o", 66'(timer_write_o), 66'(1'b1));
            check_value("timer_packet_o", timer_packet_o, pkt);
            exp_timer++;
        end else begin
            check_value("timer_write_o", 66'(timer_write_o), 66'(1'b0));
            res_exp.push_back(cls);
            if (cls == "B") begin
                buf_exp.push_back(pkt);
            end else if (cls == "D") begin
                direct_pkt     = pkt;
                direct_pending = 1'b1;
            end else if (cls != "X") begin
                fail_run("unknown store class in the stimulus file");
            end
        end
    endtask

    // A finished write is either the pending IO store or the oldest buffered one
    task automatic check_write();
        if (direct_pending && mem_packet_o == direct_pkt) begin
            direct_pending = 1'b0;
            bypass_count   = 0;
        end else begin
            if (buf_exp.size() == 0) begin
                fail_run("memory write with no buffered store pending");
            end
            check_value("mem_packet_o", mem_packet_o, buf_exp[0]);
            void'(buf_exp.pop_front());
            // Only the write already in flight may finish ahead of an IO store
            if (direct_pending) begin
                bypass_count++;
                if (bypass_count > 1) begin
                    fail_run("buffered store written ahead of a pending IO store");
                end
            end
        end
    endtask

    task automatic check_result();
        if (res_exp.size() == 0) begin
            fail_run("data_valid_o raised with no store pending");
        end
        // Flags are checked in the first cycle of each result
        if (!result_seen) begin
            check_value("illegal_access_o", 66'(illegal_access_o), 66'(res_exp[0] == "X"));
            if (res_exp[0] == "D" && direct_pending) begin
                fail_run("data_valid_o raised before the IO store was written");
            end
            result_seen = 1'b1;
        end
        if (data_accepted_i) begin
            void'(res_exp.pop_front());
            result_seen = 1'b0;
        end
    endtask

    always @(posedge clk_i) begin : scoreboard
        if (rst_n_i) begin
            if (timer_write_o) begin
                timer_count++;
            end
            if (mem_req_o && mem_done_i) begin
                check_write();
            end
            if (data_valid_o) begin
                check_result();
            end
        end
    end

    // ==========================================================
    // Issue stage acceptance and memory with random latency
    // ==========================================================

    always @(posedge clk_i) begin : responder
        int draw;
        if (!rst_n_i) begin
            data_accepted_i <= 1'b0;
            mem_done_i      <= 1'b0;
            mem_armed       <= 1'b0;
        end else begin
            // Accepts three results out of four on average
            data_accepted_i <= (($random(seed) & 3) != 0);
            mem_done_i      <= 1'b0;
            if (mem_req_o && !mem_done_i) begin
                if (!mem_armed) begin
                    draw = $random(seed) & 3;
                    if (draw == 0) begin
                        mem_done_i <= 1'b1;
                    end else begin
                        mem_armed <= 1'b1;
                        mem_wait  <= draw - 1;
                    end
                end else if (mem_wait == 0) begin
                    mem_done_i <= 1'b1;
                    mem_armed  <= 1'b0;
                end else begin
                    mem_wait <= mem_wait - 1;
                end
            end
        end
    end

    initial begin : watchdog
        wait (timeout_limit != 0);
        forever begin
            @(posedge clk_i);
            cycle_count++;
            if (cycle_count > timeout_limit) begin
                fail_run("timeout, the DUT stopped making progress");
            end
        end
    end

    initial begin : stimulus
        int                     fd;
        string                  line;
        logic                   prv;
        logic [31:0]            addr;
        logic [31:0]            data;
        logic [1:0]             width;
        logic [7:0]             cls;
        stu_pkg::store_packet_t pkt;

        rst_n_i           = 1'b0;
        valid_operation_i = 1'b0;
        store_packet_i    = '0;
        prv_level_i       = 1'b0;

        fd = $fopen("test/store_input.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open test/store_input.txt");
        end
        while ($fgets(line, fd) != 0) begin
            // Lines starting with a hash describe the columns
            if (line.len() > 1 && line.getc(0) != "#") begin
                if ($sscanf(line, "%h %h %h %h %c", prv, addr, data, width, cls) != 5) begin
                    fail_run("malformed line in test/store_input.txt");
                end
                pkt.data    = data;
                pkt.address = addr;
                pkt.width   = stu_pkg::store_width_t'(width);
                stim_pkt.push_back(pkt);
                stim_prv.push_back(prv);
                stim_cls.push_back(cls);
            end
        end
        $fclose(fd);
        timeout_limit = stim_pkt.size() * 40 + 100;

        repeat (8) @(posedge clk_i);

        // Outputs right out of reset
        check_value("idle_o", 66'(idle_o), 66'(1'b1));
        check_value("data_valid_o", 66'(data_valid_o), 66'(1'b0));
        check_value("illegal_access_o", 66'(illegal_access_o), 66'(1'b0));
        check_value("timer_write_o", 66'(timer_write_o), 66'(1'b0));
        check_value("mem_req_o", 66'(mem_req_o), 66'(1'b0));
        rst_n_i <= 1'b1;

        foreach (stim_pkt[i]) begin
            @(posedge clk_i);
            valid_operation_i <= 1'b1;
            store_packet_i    <= stim_pkt[i];
            prv_level_i       <= stim_prv[i];
            // The store is taken at the first edge that sees idle_o high
            do begin
                @(posedge clk_i);
            end while (!idle_o);
            valid_operation_i <= 1'b0;
            record_issue(stim_pkt[i], stim_cls[i]);
        end

        // Let results, the buffer and the memory port drain
        while (res_exp.size() != 0 || buf_exp.size() != 0 || direct_pending || mem_req_o) begin
            @(posedge clk_i);
        end

        check_value("timer write count", 66'(timer_count), 66'(exp_timer));

        $display("TEST OK");
        $finish;
    end

endmodule : store_subsystem_tb

// ==== test/store_input.txt ====
# prv address data width class (hex fields, prv 1 is machine mode)
# width 0 byte 1 half 2 word; class T timer, B buffered, D direct IO, X illegal
1 00002000 a5a50001 2 B
0 00002004 a5a50002 1 B
1 00001100 c0de0001 2 D
1 00001000 7117e001 2 T
1 00000800 dead0001 2 X
0 00001800 dead0002 2 X
0 0000100c 7117e002 1 T
1 00003000 b0b00001 2 B
1 00003004 b0b00002 2 B
0 00003008 b0b00003 0 B
1 0000300c b0b00004 2 B
1 00003010 b0b00005 1 B
1 00003014 b0b00006 2 B
0 00003018 b0b00007 2 B
1 0000301c b0b00008 0 B
1 00003020 b0b00009 2 B
1 00003024 b0b0000a 2 B
1 00001ffc c0de0002 2 D

// ==== sources.f ====
src/stu_pkg.sv
src/store_unit.sv
src/store_buffer.sv
src/store_controller.sv
src/store_subsystem.sv
test/store_subsystem_props.sv
test/store_subsystem_tb.sv

// ==== Makefile ====
# Verilator flow for the store subsystem

VERILATOR  ?= verilator
TOP        ?= store_subsystem_tb
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= --lint-only

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The simulation binary exits non-zero when the testbench stops with $fatal
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
